/* dac_pkg.sv */
`default_nettype none

package dac_pkg;

    // table word layout
    localparam int ENTRY_W = 44;
    localparam int ADDR_W  = 5;

    // code_a in [15:0], code_b in [31:16]
    localparam int CODE_W = 16;

    // dwell field in [43:32]
    localparam int HOLD_W = 12;

    // shortest time a code pair stays on the outputs
    localparam int MIN_DWELL = 3;

    // host command opcodes
    typedef enum logic [2:0] {
        op_write    = 3'd0,
        op_read     = 3'd1,
        op_set_last = 3'd2,
        op_start    = 3'd3,
        op_stop     = 3'd4
    } dac_op_e;

    // player control states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_prime = 2'd1,
        st_run   = 2'd2
    } dac_state_e;

endpackage

`default_nettype wire

/* dac_table_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_table_ram #(
    parameter int DEPTH = 32
) (
    input  wire                          rd_clk,
    input  wire                          reset,
    input  wire                          web,
    input  wire  [dac_pkg::ADDR_W-1:0]   addr,
    input  wire  [dac_pkg::ENTRY_W-1:0]  din,
    output logic [dac_pkg::ENTRY_W-1:0]  dout
);
    import dac_pkg::*;

    logic [ENTRY_W-1:0] mem [DEPTH];
    logic               in_range;

    // addresses past the table end read as zero and ignore writes
    assign in_range = (int'(addr) < DEPTH);

    always_ff @(posedge rd_clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                mem[i] <= '0;
            end
            dout <= '0;
        end
        else
        begin
            if (!web && in_range)
            begin
                mem[addr] <= din;
            end
            // registered read, one cycle of latency
            dout <= in_range ? mem[addr] : '0;
        end
    end

endmodule

`default_nettype wire

/* dac_seq_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_seq_ctrl (
    input  wire                          rd_clk,
    input  wire                          reset,
    input  wire                          cmd_valid,
    input  var   dac_pkg::dac_op_e       cmd_op,
    input  wire  [dac_pkg::ADDR_W-1:0]   cmd_addr,
    input  wire  [dac_pkg::ENTRY_W-1:0]  cmd_data,
    input  wire                          fetch,
    input  wire  [dac_pkg::ADDR_W-1:0]   fetch_addr,
    input  wire  [dac_pkg::ENTRY_W-1:0]  ram_dout,
    output logic                         ram_web,
    output logic [dac_pkg::ADDR_W-1:0]   ram_addr,
    output logic [dac_pkg::ENTRY_W-1:0]  ram_din,
    output logic                         seq_clear,
    output logic                         play_en,
    output logic [dac_pkg::ADDR_W-1:0]   last_addr,
    output logic                         running,
    output logic [dac_pkg::ENTRY_W-1:0]  rd_data,
    output logic                         rd_valid,
    output logic                         cmd_err
);
    import dac_pkg::*;

    dac_state_e         state;
    logic               busy;
    logic               take_start;
    logic               take_stop;
    logic               table_cmd;
    logic               host_write;
    logic               host_read;
    logic               host_last;
    logic               rd_mark;
    logic               rd_mark2;
    logic               err_mark;
    logic               err_mark2;
    logic [ENTRY_W-1:0] rd_hold;

    assign busy       = (state != st_idle);
    assign take_start = cmd_valid && (cmd_op == op_start);
    assign take_stop  = cmd_valid && (cmd_op == op_stop);
    assign table_cmd  = cmd_valid && ((cmd_op == op_write) || (cmd_op == op_read) ||
                                      (cmd_op == op_set_last));
    assign host_write = table_cmd && !busy && (cmd_op == op_write);
    assign host_read  = table_cmd && !busy && (cmd_op == op_read);
    assign host_last  = table_cmd && !busy && (cmd_op == op_set_last);

    assign running = busy;

    // start or stop in flight flushes the output pipeline at this edge
    assign play_en = busy && !take_start && !take_stop;

    // host owns the RAM port in idle, the address generator otherwise
    always_comb
    begin
        if (busy)
        begin
            ram_addr = fetch_addr;
            ram_web  = 1'b1;
        end
        else
        begin
            ram_addr = cmd_addr;
            ram_web  = !host_write;
        end
    end

    assign ram_din = cmd_data;

    always_ff @(posedge rd_clk)
    begin
        if (reset)
        begin
            state <= st_idle;
        end
        else if (take_start)
        begin
            state <= st_prime;
        end
        else if (take_stop)
        begin
            state <= st_idle;
        end
        else if ((state == st_prime) && fetch)
        begin
            state <= st_run;
        end
    end

    always_ff @(posedge rd_clk)
    begin
        if (reset)
        begin
            seq_clear <= 1'b0;
            last_addr <= '1;
            rd_mark   <= 1'b0;
            rd_mark2  <= 1'b0;
            rd_valid  <= 1'b0;
            rd_data   <= '0;
            err_mark  <= 1'b0;
            err_mark2 <= 1'b0;
            cmd_err   <= 1'b0;
        end
        else
        begin
            seq_clear <= take_start;
            if (host_last)
            begin
                last_addr <= cmd_addr;
            end
            rd_mark  <= host_read;
            rd_mark2 <= rd_mark;
            rd_valid <= rd_mark2;
            if (rd_mark2)
            begin
                rd_data <= rd_hold;
            end
            // errors share the read latency, so the two results never overlap
            err_mark  <= table_cmd && busy;
            err_mark2 <= err_mark;
            cmd_err   <= err_mark2;
        end
    end

    always_ff @(posedge rd_clk)
    begin
        if (rd_mark)
        begin
            rd_hold <= ram_dout;
        end
    end

endmodule

`default_nettype wire

/* dac_addr_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_addr_gen #(
    parameter int DEPTH = 32
) (
    input  wire                         rd_clk,
    input  wire                         reset,
    input  wire                         seq_clear,
    input  wire                         play_en,
    input  wire  [dac_pkg::ADDR_W-1:0]  last_addr,
    input  wire                         need_next,
    output logic                        fetch,
    output logic [dac_pkg::ADDR_W-1:0]  fetch_addr
);
    import dac_pkg::*;

    localparam logic [ADDR_W-1:0] TOP_ADDR = ADDR_W'(DEPTH - 1);

    logic [1:0]        prime_cnt;
    logic [ADDR_W-1:0] next_addr;
    logic              at_wrap;

    // wrap at the loop end, or at the table end if last_addr is past it
    assign at_wrap = (next_addr == last_addr) || (next_addr == TOP_ADDR);

    // two priming fetches, then one per consumed entry
    assign fetch      = play_en && !seq_clear && ((prime_cnt != 2'd0) || need_next);
    assign fetch_addr = next_addr;

    always_ff @(posedge rd_clk)
    begin
        if (reset)
        begin
            prime_cnt <= 2'd0;
            next_addr <= '0;
        end
        else if (seq_clear)
        begin
            prime_cnt <= 2'd2;
            next_addr <= '0;
        end
        else if (!play_en)
        begin
            prime_cnt <= 2'd0;
        end
        else if (fetch)
        begin
            if (prime_cnt != 2'd0)
            begin
                prime_cnt <= prime_cnt - 2'd1;
            end
            next_addr <= at_wrap ? '0 : next_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* dac_code_out.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_code_out (
    input  wire                          rd_clk,
    input  wire                          reset,
    input  wire                          play_en,
    input  wire                          fetch,
    input  wire  [dac_pkg::ENTRY_W-1:0]  ram_dout,
    output logic                         need_next,
    output logic [dac_pkg::CODE_W-1:0]   dac_a,
    output logic [dac_pkg::CODE_W-1:0]   dac_b,
    output logic                         dac_update
);
    import dac_pkg::*;

    localparam logic [HOLD_W:0] MIN_SPAN = (HOLD_W + 1)'(MIN_DWELL);

    logic [ENTRY_W-1:0] stage;
    logic               stage_full;
    logic               stage_load;
    logic               out_full;
    logic               rd_pend;
    logic [HOLD_W:0]    dwell_cnt;
    logic               expire;

    // dwell of an entry: hold+1, never below MIN_DWELL
    function automatic logic [HOLD_W:0] dwell_of(input logic [ENTRY_W-1:0] entry);
        logic [HOLD_W:0] span;
        span = {1'b0, entry[2*CODE_W +: HOLD_W]} + 1'b1;
        return (span < MIN_SPAN) ? MIN_SPAN : span;
    endfunction

    assign expire     = out_full && stage_full && (dwell_cnt == 1);
    assign stage_load = play_en && rd_pend && out_full;

    always_ff @(posedge rd_clk)
    begin
        if (reset)
        begin
            rd_pend    <= 1'b0;
            out_full   <= 1'b0;
            stage_full <= 1'b0;
            dwell_cnt  <= '0;
            dac_update <= 1'b0;
            need_next  <= 1'b0;
            dac_a      <= '0;
            dac_b      <= '0;
        end
        else if (!play_en)
        begin
            // flush, but the codes stay on the outputs
            rd_pend    <= 1'b0;
            out_full   <= 1'b0;
            stage_full <= 1'b0;
            dwell_cnt  <= '0;
            dac_update <= 1'b0;
            need_next  <= 1'b0;
        end
        else
        begin
            rd_pend    <= fetch;
            dac_update <= 1'b0;
            need_next  <= 1'b0;
            if (dwell_cnt > 1)
            begin
                dwell_cnt <= dwell_cnt - 1'b1;
            end
            if (rd_pend && !out_full)
            begin
                // first entry of a run goes straight out
                dac_a      <= ram_dout[CODE_W-1:0];
                dac_b      <= ram_dout[CODE_W +: CODE_W];
                dwell_cnt  <= dwell_of(ram_dout);
                out_full   <= 1'b1;
                dac_update <= 1'b1;
            end
            else if (expire)
            begin
                dac_a      <= stage[CODE_W-1:0];
                dac_b      <= stage[CODE_W +: CODE_W];
                dwell_cnt  <= dwell_of(stage);
                dac_update <= 1'b1;
                need_next  <= 1'b1;
                stage_full <= 1'b0;
            end
            if (stage_load)
            begin
                stage_full <= 1'b1;
            end
        end
    end

    always_ff @(posedge rd_clk)
    begin
        if (stage_load)
        begin
            stage <= ram_dout;
        end
    end

endmodule

`default_nettype wire

/* dac_player_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_player_top #(
    parameter int DEPTH = 32
) (
    input  wire                          rd_clk,
    input  wire                          reset,
    input  wire                          cmd_valid,
    input  var   dac_pkg::dac_op_e       cmd_op,
    input  wire  [dac_pkg::ADDR_W-1:0]   cmd_addr,
    input  wire  [dac_pkg::ENTRY_W-1:0]  cmd_data,
    output logic [dac_pkg::CODE_W-1:0]   dac_a,
    output logic [dac_pkg::CODE_W-1:0]   dac_b,
    output logic                         dac_update,
    output logic                         running,
    output logic [dac_pkg::ENTRY_W-1:0]  rd_data,
    output logic                         rd_valid,
    output logic                         cmd_err
);
    import dac_pkg::*;

    logic               ram_web;
    logic [ADDR_W-1:0]  ram_addr;
    logic [ENTRY_W-1:0] ram_din;
    logic [ENTRY_W-1:0] ram_dout;
    logic               seq_clear;
    logic               play_en;
    logic [ADDR_W-1:0]  last_addr;
    logic               fetch;
    logic [ADDR_W-1:0]  fetch_addr;
    logic               need_next;

    dac_seq_ctrl i_ctrl (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .fetch      (fetch),
        .fetch_addr (fetch_addr),
        .ram_dout   (ram_dout),
        .ram_web    (ram_web),
        .ram_addr   (ram_addr),
        .ram_din    (ram_din),
        .seq_clear  (seq_clear),
        .play_en    (play_en),
        .last_addr  (last_addr),
        .running    (running),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .cmd_err    (cmd_err)
    );

    dac_table_ram #(
        .DEPTH (DEPTH)
    ) i_ram (
        .rd_clk (rd_clk),
        .reset  (reset),
        .web    (ram_web),
        .addr   (ram_addr),
        .din    (ram_din),
        .dout   (ram_dout)
    );

    dac_addr_gen #(
        .DEPTH (DEPTH)
    ) i_addr (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .seq_clear  (seq_clear),
        .play_en    (play_en),
        .last_addr  (last_addr),
        .need_next  (need_next),
        .fetch      (fetch),
        .fetch_addr (fetch_addr)
    );

    dac_code_out i_out (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .play_en    (play_en),
        .fetch      (fetch),
        .ram_dout   (ram_dout),
        .need_next  (need_next),
        .dac_a      (dac_a),
        .dac_b      (dac_b),
        .dac_update (dac_update)
    );

endmodule

`default_nettype wire

/* dac_player_props.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_player_props (
    input wire rd_clk,
    input wire reset,
    input wire dac_update,
    input wire running,
    input wire rd_valid,
    input wire cmd_err
);
    int fail_cnt = 0;

    // updates only come from a running player
    update_in_run: assert property (@(posedge rd_clk) disable iff (reset)
        $rose(dac_update) |-> running)
    else
    begin
        $error("dac_update rose while running was low");
        fail_cnt++;
    end

    read_err_apart: assert property (@(posedge rd_clk) disable iff (reset)
        !(rd_valid && cmd_err))
    else
    begin
        $error("rd_valid and cmd_err high in the same cycle");
        fail_cnt++;
    end

    quiet_after_reset: assert property (@(posedge rd_clk)
        reset |=> (!dac_update && !running && !rd_valid && !cmd_err))
    else
    begin
        $error("control outputs not low in the cycle after reset");
        fail_cnt++;
    end

endmodule

bind dac_player_top dac_player_props i_props (
    .rd_clk     (rd_clk),
    .reset      (reset),
    .dac_update (dac_update),
    .running    (running),
    .rd_valid   (rd_valid),
    .cmd_err    (cmd_err)
);

`default_nettype wire

/* tb_dac_player.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dac_player;
    import dac_pkg::*;

    localparam int HOLD_MAX  = 40;
    localparam int N_RUNS    = 4;
    localparam int N_CMDS    = 260;
    // per command, then per run the longest loop at the longest dwell, plus margin
    localparam int CYCLE_MAX = N_CMDS * 12 + N_RUNS * (3 * 32 + 10) * (HOLD_MAX + 1) + 1000;

    logic               rd_clk;
    logic               reset;
    logic               cmd_valid;
    dac_op_e            cmd_op;
    logic [ADDR_W-1:0]  cmd_addr;
    logic [ENTRY_W-1:0] cmd_data;
    logic [CODE_W-1:0]  dac_a;
    logic [CODE_W-1:0]  dac_b;
    logic               dac_update;
    logic               running;
    logic [ENTRY_W-1:0] rd_data;
    logic               rd_valid;
    logic               cmd_err;

    // table and loop model
    logic [ENTRY_W-1:0] model [32];
    int                 model_last = 31;
    bit                 model_run  = 1'b0;
    bit                 have_prev  = 1'b0;
    int                 exp_idx    = 0;
    int                 exp_gap    = 0;
    int                 since_upd  = 0;
    int                 upd_cnt    = 0;
    int                 err_seen   = 0;
    int                 rd_seen    = 0;
    int                 rd_exp     = 0;
    int                 errors     = 0;
    int                 cycles     = 0;
    logic [CODE_W-1:0]  last_a     = '0;
    logic [CODE_W-1:0]  last_b     = '0;

    dac_player_top #(
        .DEPTH (32)
    ) i_dac_player_top (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .dac_a      (dac_a),
        .dac_b      (dac_b),
        .dac_update (dac_update),
        .running    (running),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .cmd_err    (cmd_err)
    );

    initial
    begin
        rd_clk = 1'b0;
        forever #10 rd_clk = ~rd_clk;
    end

    initial
    begin
        while (cycles < CYCLE_MAX)
        begin
            @(posedge rd_clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_MAX);
        $display("STATUS: FAIL");
        $finish;
    end

    // dwell rule: hold+1 cycles, at least MIN_DWELL
    function automatic int dwell_cycles(input logic [ENTRY_W-1:0] entry);
        int span;
        span = int'(entry[2*CODE_W +: HOLD_W]) + 1;
        return (span < MIN_DWELL) ? MIN_DWELL : span;
    endfunction

    function automatic logic [ENTRY_W-1:0] rand_entry();
        logic [HOLD_W-1:0] hold;
        case ($urandom_range(3))
            0: hold = '0;
            1: hold = HOLD_W'(1);
            2: hold = HOLD_W'($urandom_range(10, 2));
            default: hold = HOLD_W'($urandom_range(HOLD_MAX, 11));
        endcase
        return {hold, CODE_W'($urandom), CODE_W'($urandom)};
    endfunction

    task automatic check_entry(input logic [ENTRY_W-1:0] got, input logic [ENTRY_W-1:0] exp,
                               input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_codes(input logic [CODE_W-1:0] got_a, input logic [CODE_W-1:0] got_b,
                               input logic [CODE_W-1:0] exp_a, input logic [CODE_W-1:0] exp_b,
                               input string what);
        if ((got_a !== exp_a) || (got_b !== exp_b))
        begin
            errors++;
            $display("FAIL %0t ns: %s got a=%h b=%h, expected a=%h b=%h",
                     $time, what, got_a, got_b, exp_a, exp_b);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            errors++;
            $display("FAIL %0t ns: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one clock cycle, outputs observed at the falling edge
    task automatic tick();
        @(negedge rd_clk);
        since_upd++;
        if (cmd_err === 1'b1)
        begin
            err_seen++;
        end
        if (rd_valid === 1'b1)
        begin
            rd_seen++;
        end
        if (dac_update === 1'b1)
        begin
            if (!model_run)
            begin
                errors++;
                $display("FAIL %0t ns: dac_update pulsed while the player was stopped", $time);
            end
            else
            begin
                check_codes(dac_a, dac_b, model[exp_idx][CODE_W-1:0],
                            model[exp_idx][CODE_W +: CODE_W], "update codes");
                if (have_prev)
                begin
                    check_count(since_upd, exp_gap, "update spacing");
                end
                last_a    = model[exp_idx][CODE_W-1:0];
                last_b    = model[exp_idx][CODE_W +: CODE_W];
                exp_gap   = dwell_cycles(model[exp_idx]);
                exp_idx   = (exp_idx == model_last) ? 0 : exp_idx + 1;
                have_prev = 1'b1;
                since_upd = 0;
                upd_cnt++;
            end
        end
    endtask

    task automatic send(input dac_op_e op, input int addr, input logic [ENTRY_W-1:0] data);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = ADDR_W'(addr);
        cmd_data  = data;
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic write_entry(input int idx, input logic [ENTRY_W-1:0] data);
        send(op_write, idx, data);
        model[idx] = data;
    endtask

    // rd_valid must show up exactly two cycles after the accepting edge
    task automatic read_check(input int idx);
        send(op_read, idx, '0);
        rd_exp++;
        check_flag(rd_valid, 1'b0, "rd_valid one cycle after read");
        tick();
        check_flag(rd_valid, 1'b0, "rd_valid two edges after read");
        tick();
        check_flag(rd_valid, 1'b1, "rd_valid at read latency");
        check_entry(rd_data, model[idx], "read-back");
    endtask

    task automatic illegal_cmd(input dac_op_e op);
        int err_before;
        int rd_before;
        int waited;
        err_before = err_seen;
        rd_before  = rd_seen;
        waited     = 0;
        send(op, $urandom_range(31), rand_entry());
        while ((err_seen == err_before) && (waited < 8))
        begin
            tick();
            waited++;
        end
        tick();
        tick();
        check_count(err_seen - err_before, 1, "cmd_err pulses for rejected command");
        check_count(rd_seen - rd_before, 0, "rd_valid pulses for rejected command");
    endtask

    task automatic start_play();
        exp_idx   = 0;
        have_prev = 1'b0;
        model_run = 1'b1;
        send(op_start, 0, '0);
        check_flag(running, 1'b1, "running after start");
    endtask

    task automatic stop_play();
        model_run = 1'b0;
        send(op_stop, 0, '0);
        check_flag(running, 1'b0, "running after stop");
        check_flag(dac_update, 1'b0, "dac_update after stop");
        repeat (2 * (HOLD_MAX + 1))
        begin
            tick();
        end
        check_codes(dac_a, dac_b, last_a, last_b, "codes held after stop");
    endtask

    task automatic wait_updates(input int n);
        int target;
        target = upd_cnt + n;
        while (upd_cnt < target)
        begin
            tick();
        end
    endtask

    initial
    begin
        int idx;
        int run;
        int prop_fails;
        logic [ENTRY_W-1:0] data;

        void'($urandom(32'h37ff_b5c0));
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = op_write;
        cmd_addr  = '0;
        cmd_data  = '0;
        for (int i = 0; i < 32; i++)
        begin
            model[i] = '0;
        end
        repeat (5)
        begin
            tick();
        end
        reset = 1'b0;

        // quiet outputs and an empty table after reset
        check_flag(running, 1'b0, "running after reset");
        check_flag(dac_update, 1'b0, "dac_update after reset");
        check_flag(rd_valid, 1'b0, "rd_valid after reset");
        check_flag(cmd_err, 1'b0, "cmd_err after reset");
        check_codes(dac_a, dac_b, '0, '0, "codes after reset");
        check_entry(rd_data, '0, "rd_data after reset");
        for (int i = 0; i < 8; i++)
        begin
            read_check($urandom_range(31));
        end

        for (int i = 0; i < 32; i++)
        begin
            write_entry(i, rand_entry());
        end
        for (int i = 0; i < 40; i++)
        begin
            idx = $urandom_range(31);
            if ($urandom_range(3) == 0)
            begin
                // read lands in the cycle right after the write
                data = rand_entry();
                write_entry(idx, data);
            end
            read_check(idx);
        end

        for (run = 0; run < N_RUNS; run++)
        begin
            model_last = (run == N_RUNS - 1) ? 0 : $urandom_range(31);
            send(op_set_last, model_last, '0);
            start_play();
            wait_updates(2 * (model_last + 1) + 2);
            if (run == 0)
            begin
                illegal_cmd(op_write);
                illegal_cmd(op_read);
                illegal_cmd(op_set_last);
                // a full loop shows whether the loop end moved
                wait_updates(model_last + 4);
            end
            if (run == 1)
            begin
                start_play();
                wait_updates(model_last + 3);
            end
            stop_play();
            for (int i = 0; i < 32; i++)
            begin
                read_check(i);
            end
        end

        tick();
        check_count(err_seen, 3, "cmd_err pulses in total");
        check_count(rd_seen, rd_exp, "rd_valid pulses in total");
        prop_fails = i_dac_player_top.i_props.fail_cnt;
        $display("checks failed: %0d, assertions failed: %0d, updates seen: %0d",
                 errors, prop_fails, upd_cnt);
        if ((errors == 0) && (prop_fails == 0))
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
dac_pkg.sv
dac_table_ram.sv
dac_seq_ctrl.sv
dac_addr_gen.sv
dac_code_out.sv
dac_player_top.sv
dac_player_props.sv
tb_dac_player.sv
